/* countConnectedCore.f */
+incdir+include
rtl/graphPkg.sv
rtl/loopPkg.sv
rtl/hyperpipe.sv
rtl/hypercubeClosure.sv
rtl/newSeedProduction.sv
rtl/explorationPipeline.sv
rtl/countConnectedLoop.sv
rtl/countConnectedCore.sv
verification/countConnected_assert.sv
verification/countConnectedTb.sv

/* Makefile */
# Verilator flow for the connected component counter

SIM       = verilator
SIM_FLAGS = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
RUN_FLAGS = +verilator+error+limit+100
TOP       = countConnectedTb
FILELIST  = countConnectedCore.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* include/componentRef.svh */
`ifndef COMPONENT_REF_SVH
`define COMPONENT_REF_SVH

// all supersets of the vertices in s
function automatic graphPkg::graph_t supersetsOf(graphPkg::graph_t s);
    graphPkg::graph_t r;
    r = '0;
    for (int v = 0; v < graphPkg::graphBits; v++) begin
        for (int w = 0; w < graphPkg::graphBits; w++) begin
            if (s[v] && ((v & w) == v)) begin
                r[w] = 1'b1;
            end
        end
    end
    return r;
endfunction

// all subsets of the vertices in s
function automatic graphPkg::graph_t subsetsOf(graphPkg::graph_t s);
    graphPkg::graph_t r;
    r = '0;
    for (int v = 0; v < graphPkg::graphBits; v++) begin
        for (int w = 0; w < graphPkg::graphBits; w++) begin
            if (s[v] && ((v & w) == w)) begin
                r[w] = 1'b1;
            end
        end
    end
    return r;
endfunction

// peel off one component at a time, starting from the lowest vertex
function automatic int countComponents(graphPkg::graph_t g);
    graphPkg::graph_t left;
    graphPkg::graph_t comp;
    graphPkg::graph_t prev;
    int count;
    left = g;
    count = 0;
    while (left != '0) begin
        comp = left & (~left + 1'b1);
        do begin
            prev = comp;
            comp = (supersetsOf(comp) | subsetsOf(comp)) & left;
        end while (comp != prev);
        left = left & ~comp;
        count++;
    end
    return count;
endfunction

// 32-bit xorshift step with shifts 13, 17 and 5
function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

`endif

/* verification/countConnectedTb.sv */
`default_nettype none
`timescale 1ns/1ps

module countConnectedTb
    import graphPkg::*;
    import loopPkg::*;
();

    localparam int EXTRA_DATA_WIDTH = 10;
    localparam int DATA_IN_LATENCY = 4;
    localparam int lapCycles = seedLatency + midLatency + explorationLatency + outLatency
        + DATA_IN_LATENCY;
    localparam int numFixed = 5;
    localparam int numRandom = 20;
    localparam int numEntries = numFixed + numRandom;
    localparam int slotWaitLimit = 5000;
    localparam int finishWaitLimit = 20000;

    `include "componentRef.svh"

    logic clk;
    logic reset;
    logic request;
    graph_t graphIn;
    logic start;
    count_t connectCountIn;
    logic [EXTRA_DATA_WIDTH-1:0] extraDataIn;
    logic done;
    count_t connectCount;
    logic [EXTRA_DATA_WIDTH-1:0] extraDataOut;

    // one row of stimulus and expected count per graph, tagged by its row index
    graph_t tableGraph [numEntries];
    count_t tableOffset [numEntries];
    count_t tableExpect [numEntries];
    bit started [numEntries];
    bit reported [numEntries];

    logic [DATA_IN_LATENCY-1:0] requestHistory;
    logic slotReady;
    logic [31:0] rngState;
    int startCount;
    int doneCount;
    int checkCount;
    int valueErrors;
    int otherErrors;

    countConnectedCore #(
        .EXTRA_DATA_WIDTH (EXTRA_DATA_WIDTH),
        .DATA_IN_LATENCY  (DATA_IN_LATENCY)
    ) UUT (
        .clk            (clk),
        .reset          (reset),
        .request        (request),
        .graphIn        (graphIn),
        .start          (start),
        .connectCountIn (connectCountIn),
        .extraDataIn    (extraDataIn),
        .done           (done),
        .connectCount   (connectCount),
        .extraDataOut   (extraDataOut)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fillTable();
        graph_t g;
        int row;
        tableGraph[0] = '0;
        tableGraph[1] = graph_t'(1);
        tableGraph[2] = '1;
        // the seven weight-1 vertices
        tableGraph[3] = '0;
        for (int b = 0; b < 7; b++) begin
            tableGraph[3][1 << b] = 1'b1;
        end
        // vertices 1 and 2 joined through 3
        tableGraph[4] = graph_t'(4'b1110);
        tableExpect[0] = 6'd0;
        tableExpect[1] = 6'd1;
        tableExpect[2] = 6'd1;
        tableExpect[3] = 6'd7;
        tableExpect[4] = 6'd1;
        for (int e = 0; e < numFixed; e++) begin
            tableOffset[e] = '0;
        end
        rngState = 32'hb25a_b4e3;
        for (int k = 0; k < numRandom; k++) begin
            row = numFixed + k;
            // density 1/2 down to 1/16
            g = '1;
            for (int d = 0; d <= k % 4; d++) begin
                for (int w = 0; w < 4; w++) begin
                    rngState = xorshift32(rngState);
                    g[32*w +: 32] = g[32*w +: 32] & rngState;
                end
            end
            tableGraph[row] = g;
            tableOffset[row] = count_t'((k % 3) * 5);
            tableExpect[row] = count_t'(countComponents(g)) + tableOffset[row];
        end
    endtask

    task automatic checkOutputs();
        int tag;
        if ($isunknown({request, done})) begin
            $display("error at %0t ns: request or done is unknown", $time);
            valueErrors++;
        end else if (done) begin
            doneCount++;
            tag = int'(extraDataOut);
            if (!request) begin
                $display("error at %0t ns: done without request in the same cycle", $time);
                valueErrors++;
            end
            if (tag >= numEntries) begin
                $display("error at %0t ns: done with tag %0d, never issued", $time, tag);
                valueErrors++;
            end else if (!started[tag]) begin
                $display("error at %0t ns: done for entry %0d, never started", $time, tag);
                valueErrors++;
            end else if (reported[tag]) begin
                $display("error at %0t ns: entry %0d reported twice", $time, tag);
                valueErrors++;
            end else begin
                reported[tag] = 1'b1;
                checkCount++;
                if (connectCount !== tableExpect[tag]) begin
                    $display("error at %0t ns: entry %0d count %0d, expected %0d",
                        $time, tag, connectCount, tableExpect[tag]);
                    valueErrors++;
                end
            end
        end
    endtask

    // on each falling edge drop start, track request pulses and check outputs
    task automatic nextEdge();
        @(negedge clk);
        start = 1'b0;
        slotReady = requestHistory[DATA_IN_LATENCY-1];
        requestHistory = {requestHistory[DATA_IN_LATENCY-2:0], request};
        checkOutputs();
    endtask

    initial begin
        int waited;
        bit sawRequest;
        bit stalled;
        reset = 1'b1;
        graphIn = '0;
        start = 1'b0;
        connectCountIn = '0;
        extraDataIn = '0;
        requestHistory = '0;
        slotReady = 1'b0;
        startCount = 0;
        doneCount = 0;
        checkCount = 0;
        valueErrors = 0;
        otherErrors = 0;
        for (int e = 0; e < numEntries; e++) begin
            started[e] = 1'b0;
            reported[e] = 1'b0;
        end
        fillTable();

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // idle slots ask for work within one lap
        waited = 0;
        sawRequest = 1'b0;
        while (!sawRequest && waited < lapCycles) begin
            nextEdge();
            sawRequest = request;
            waited++;
        end
        if (!sawRequest) begin
            $display("no request pulse within one lap after reset");
            otherErrors++;
        end

        stalled = 1'b0;
        for (int e = 0; e < numEntries && !stalled; e++) begin
            waited = 0;
            nextEdge();
            while (!slotReady && waited < slotWaitLimit) begin
                nextEdge();
                waited++;
            end
            if (!slotReady) begin
                $display("no free slot for entry %0d within %0d cycles", e, slotWaitLimit);
                otherErrors++;
                stalled = 1'b1;
            end else begin
                graphIn = tableGraph[e];
                connectCountIn = tableOffset[e];
                extraDataIn = EXTRA_DATA_WIDTH'(e);
                start = 1'b1;
                started[e] = 1'b1;
                startCount++;
            end
        end

        waited = 0;
        while (doneCount < startCount && waited < finishWaitLimit) begin
            nextEdge();
            waited++;
        end
        if (doneCount < startCount) begin
            $display("only %0d of %0d graphs finished within %0d cycles",
                doneCount, startCount, finishWaitLimit);
            otherErrors++;
        end

        // unstarted slots must stay quiet
        repeat (3 * lapCycles) nextEdge();

        if (doneCount != startCount) begin
            $display("%0d done pulses seen for %0d starts", doneCount, startCount);
            otherErrors++;
        end
        if (startCount != numEntries) begin
            $display("only %0d of %0d table entries were started", startCount, numEntries);
            otherErrors++;
        end
        for (int e = 0; e < numEntries; e++) begin
            if (started[e] && !reported[e]) begin
                $display("entry %0d was started but never reported a count", e);
                otherErrors++;
            end
        end
        if (UUT.checks.failCount != 0) begin
            $display("bound assertions failed %0d times", UUT.checks.failCount);
            otherErrors++;
        end

        $display("checks %0d, value errors %0d, other errors %0d",
            checkCount, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/countConnected_assert.sv */
`default_nettype none
`timescale 1ns/1ps

module countConnected_assert
    import graphPkg::*;
    import loopPkg::*;
#(
    parameter int EXTRA_DATA_WIDTH = 10,
    parameter int DATA_IN_LATENCY = 4
) (
    input logic                        clk,
    input logic                        reset,
    input logic                        request,
    input logic                        start,
    input logic                        done,
    input count_t                      connectCount,
    input logic [EXTRA_DATA_WIDTH-1:0] extraDataOut
);

    // loop input to output register
    localparam int loopCycles = seedLatency + midLatency + explorationLatency + outLatency;

    // failed assertions so far
    int failCount = 0;

    strobesKnown: assert property (@(posedge clk) disable iff (reset)
        !$isunknown({request, done}))
        else begin
            $error("request or done is unknown");
            failCount++;
        end

    // a finished slot is free in the same cycle
    doneFreesSlot: assert property (@(posedge clk) disable iff (reset)
        done |-> request)
        else begin
            $error("done without request in the same cycle");
            failCount++;
        end

    resultKnown: assert property (@(posedge clk) disable iff (reset)
        done |-> !$isunknown({connectCount, extraDataOut}))
        else begin
            $error("count or tag unknown while done is high");
            failCount++;
        end

    startOnFreeSlot: assert property (@(posedge clk) disable iff (reset)
        start |-> $past(request, DATA_IN_LATENCY))
        else begin
            $error("start without a free slot at the loop input");
            failCount++;
        end

    // empty slot comes round again one lap later
    idleSlotReturns: assert property (@(posedge clk) disable iff (reset)
        ($past(request, DATA_IN_LATENCY + loopCycles) && !$past(start, loopCycles))
            |-> request)
        else begin
            $error("idle slot did not request again one lap later");
            failCount++;
        end

endmodule

bind countConnectedCore countConnected_assert #(
    .EXTRA_DATA_WIDTH (EXTRA_DATA_WIDTH),
    .DATA_IN_LATENCY  (DATA_IN_LATENCY)
) checks (
    .clk          (clk),
    .reset        (reset),
    .request      (request),
    .start        (start),
    .done         (done),
    .connectCount (connectCount),
    .extraDataOut (extraDataOut)
);

`default_nettype wire

/* rtl/countConnectedCore.sv */
`default_nettype none
`timescale 1ns/1ps

module countConnectedCore
    import graphPkg::*;
    import loopPkg::*;
#(
    parameter int EXTRA_DATA_WIDTH = 10,
    parameter int DATA_IN_LATENCY = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    output logic                        request,
    input  graph_t                      graphIn,
    input  logic                        start,
    input  count_t                      connectCountIn,
    input  logic [EXTRA_DATA_WIDTH-1:0] extraDataIn,
    output logic                        done,
    output count_t                      connectCount,
    output logic [EXTRA_DATA_WIDTH-1:0] extraDataOut
);

    typedef struct packed {
        loopStateFixed_t fixed;
        logic [EXTRA_DATA_WIDTH-1:0] tag;
    } loopState_t;

    loopState_t stateIn;
    loopState_t stateOut;

    countConnectedLoop #(
        .EXTRA_DATA_WIDTH (EXTRA_DATA_WIDTH)
    ) loop (
        .clk            (clk),
        .reset          (reset),
        .stateIn        (stateIn),
        .stateOut       (stateOut),
        .graphIn        (graphIn),
        .start          (start),
        .connectCountIn (connectCountIn),
        .extraDataIn    (extraDataIn),
        .request        (request),
        .done           (done),
        .connectCount   (connectCount),
        .extraDataOut   (extraDataOut)
    );

    // external fetch latency on the way back to the loop input
    hyperpipe #(
        .CYCLES (DATA_IN_LATENCY),
        .WIDTH  ($bits(loopState_t))
    ) returnPipe (
        .clk   (clk),
        .reset (reset),
        .in    (stateOut),
        .out   (stateIn)
    );

endmodule

`default_nettype wire

/* rtl/countConnectedLoop.sv */
`default_nettype none
`timescale 1ns/1ps

module countConnectedLoop
    import graphPkg::*;
    import loopPkg::*;
#(
    parameter int EXTRA_DATA_WIDTH = 10
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [fixedStateBits+EXTRA_DATA_WIDTH-1:0] stateIn,
    output logic [fixedStateBits+EXTRA_DATA_WIDTH-1:0] stateOut,
    input  graph_t                                 graphIn,
    input  logic                                   start,
    input  count_t                                 connectCountIn,
    input  logic [EXTRA_DATA_WIDTH-1:0]            extraDataIn,
    output logic                                   request,
    output logic                                   done,
    output count_t                                 connectCount,
    output logic [EXTRA_DATA_WIDTH-1:0]            extraDataOut
);

    typedef struct packed {
        loopStateFixed_t fixed;
        logic [EXTRA_DATA_WIDTH-1:0] tag;
    } loopState_t;

    // fields that ride beside the seed and exploration stages
    typedef struct packed {
        graph_t leftover;
        logic valid;
        count_t count;
        logic [EXTRA_DATA_WIDTH-1:0] tag;
    } bypass_t;

    loopState_t carried;
    loopState_t nextState;
    bypass_t seedIn;
    bypass_t seedOut;
    bypass_t midState;
    bypass_t explOut;
    logic grabSeedIn;
    logic incrementNsd;
    graph_t curExtendingNsd;
    graph_t curExtendingMid;
    graph_t reducedExpl;
    graph_t extendedExpl;
    logic runEndExpl;
    logic grabSeedExpl;

    assign carried = stateIn;

    // a start takes over the slot, otherwise the carried state goes on
    // a start always begins with a fresh seed
    assign grabSeedIn = start | carried.fixed.grabSeed;

    always_comb begin
        seedIn.leftover = start ? graphIn : carried.fixed.leftover;
        seedIn.valid = start | (carried.fixed.valid & ~carried.fixed.runEnd);
        seedIn.count = start ? connectCountIn : carried.fixed.count;
        seedIn.tag = start ? extraDataIn : carried.tag;
    end

    newSeedProductionPipeline seedPipe (
        .clk            (clk),
        .graph          (seedIn.leftover),
        .extended       (carried.fixed.extended),
        .grabSeed       (grabSeedIn),
        .incrementCount (incrementNsd),
        .curExtending   (curExtendingNsd)
    );

    hyperpipe #(
        .CYCLES (seedLatency),
        .WIDTH  ($bits(bypass_t))
    ) seedBypass (
        .clk   (clk),
        .reset (reset),
        .in    (seedIn),
        .out   (seedOut)
    );

    // count picks up the new seed in the MID stage
    always_ff @(posedge clk) begin
        if (reset) begin
            midState <= '0;
        end else begin
            midState.leftover <= seedOut.leftover;
            midState.valid <= seedOut.valid;
            midState.count <= seedOut.count + count_t'(incrementNsd);
            midState.tag <= seedOut.tag;
        end
    end

    always_ff @(posedge clk) begin
        curExtendingMid <= curExtendingNsd;
    end

    explorationPipeline explorePipe (
        .clk          (clk),
        .leftover     (midState.leftover),
        .curExtending (curExtendingMid),
        .reduced      (reducedExpl),
        .extended     (extendedExpl),
        .runEnd       (runEndExpl),
        .grabSeedOut  (grabSeedExpl)
    );

    hyperpipe #(
        .CYCLES (explorationLatency),
        .WIDTH  ($bits(bypass_t))
    ) explorationBypass (
        .clk   (clk),
        .reset (reset),
        .in    (midState),
        .out   (explOut)
    );

    // drop the component only once its growth has settled
    always_comb begin
        nextState.fixed.leftover = grabSeedExpl ? reducedExpl : explOut.leftover;
        nextState.fixed.extended = extendedExpl;
        nextState.fixed.runEnd = runEndExpl;
        nextState.fixed.grabSeed = grabSeedExpl;
        nextState.fixed.valid = explOut.valid;
        nextState.fixed.count = explOut.count;
        nextState.tag = explOut.tag;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stateOut <= '0;
            request <= 1'b0;
            done <= 1'b0;
        end else begin
            stateOut <= nextState;
            // an empty leftover frees the slot whether started or not
            request <= runEndExpl;
            done <= explOut.valid & runEndExpl;
        end
    end

    always_ff @(posedge clk) begin
        connectCount <= explOut.count;
        extraDataOut <= explOut.tag;
    end

endmodule

`default_nettype wire

/* rtl/explorationPipeline.sv */
`default_nettype none
`timescale 1ns/1ps

module explorationPipeline
    import graphPkg::*;
(
    input  logic   clk,
    input  graph_t leftover,
    input  graph_t curExtending,
    output graph_t reduced,
    output graph_t extended,
    output logic   runEnd,
    output logic   grabSeedOut
);

    graph_t upClosure;
    graph_t midPoint;
    graph_t leftoverMid;
    graph_t downClosure;
    graph_t downSet;
    graph_t leftoverDown;
    graph_t midDown;
    graph_t reducedDown;
    graph_t extendedDown;
    logic runEndDown;
    logic growthDone;

    hypercubeClosure #(
        .UPWARD (1'b1)
    ) upClose (
        .vertices (curExtending),
        .closure  (upClosure)
    );

    // upward step kept inside the remaining vertices
    always_ff @(posedge clk) begin
        midPoint <= upClosure & leftover;
        leftoverMid <= leftover;
    end

    hypercubeClosure #(
        .UPWARD (1'b0)
    ) downClose (
        .vertices (midPoint),
        .closure  (downClosure)
    );

    always_ff @(posedge clk) begin
        downSet <= downClosure;
        leftoverDown <= leftoverMid;
        midDown <= midPoint;
    end

    assign reducedDown = leftoverDown & ~downSet;
    assign extendedDown = leftoverDown & downSet;
    assign runEndDown = (reducedDown == '0);
    // downward step added nothing, so the component is closed
    assign growthDone = (extendedDown == midDown);

    // an empty rest also ends the growth, even if the down step added vertices
    always_ff @(posedge clk) begin
        reduced <= reducedDown;
        extended <= extendedDown;
        runEnd <= runEndDown;
        grabSeedOut <= runEndDown | growthDone;
    end

endmodule

`default_nettype wire

/* rtl/newSeedProduction.sv */
`default_nettype none
`timescale 1ns/1ps

module firstBitAnalysis
    import graphPkg::*;
(
    input  logic       clk,
    input  graph_t     graph,
    output firstBits_t flags
);

    logic [31:0] hasBit4;
    logic [7:0] hasBit16;
    logic [31:0] firstBit4;

    // keeps only the lowest set bit
    function automatic logic [3:0] lowestOf4(logic [3:0] v);
        return v & (~v + 4'd1);
    endfunction

    always_comb begin
        for (int g = 0; g < 32; g++) begin
            hasBit4[g] = |graph[4*g +: 4];
        end
    end

    // the 16-level flags are registered partway and feed the second half
    always_ff @(posedge clk) begin
        for (int s = 0; s < 8; s++) begin
            hasBit16[s] <= |hasBit4[4*s +: 4];
            firstBit4[4*s +: 4] <= lowestOf4(hasBit4[4*s +: 4]);
        end
    end

    always_comb begin
        for (int h = 0; h < 2; h++) begin
            flags.hasBit64[h] = |hasBit16[4*h +: 4];
            flags.hasFirstBit16[4*h +: 4] = lowestOf4(hasBit16[4*h +: 4]);
        end
        flags.hasFirstBit4 = firstBit4;
    end

endmodule

module seedProducer
    import graphPkg::*;
(
    input  graph_t     graph,
    input  graph_t     extended,
    input  logic       grabSeed,
    input  firstBits_t flags,
    output graph_t     newExtending
);

    logic [31:0] groupFirst;
    graph_t seed;

    // 4-group holding the lowest vertex of the whole graph
    // upper half only counts when the lower half is empty
    always_comb begin
        for (int g = 0; g < 32; g++) begin
            groupFirst[g] = flags.hasFirstBit4[g] & flags.hasFirstBit16[g / 4]
                & ((g < 16) | ~flags.hasBit64[0]);
        end
    end

    // pick the pair, then the bit within the pair
    always_comb begin
        for (int g = 0; g < 32; g++) begin
            seed[4*g +: 2] = (groupFirst[g] & (|graph[4*g +: 2]))
                ? (graph[4*g] ? 2'b01 : 2'b10) : 2'b00;
            seed[4*g+2 +: 2] = (groupFirst[g] & ~(|graph[4*g +: 2]))
                ? (graph[4*g+2] ? 2'b01 : 2'b10) : 2'b00;
        end
    end

    assign newExtending = grabSeed ? seed : extended;

endmodule

module newSeedProductionPipeline
    import graphPkg::*;
(
    input  logic   clk,
    input  graph_t graph,
    input  graph_t extended,
    input  logic   grabSeed,
    output logic   incrementCount,
    output graph_t curExtending
);

    typedef struct packed {
        graph_t graph;
        graph_t extended;
        logic grabSeed;
    } seedStage_t;

    seedStage_t startStage;
    seedStage_t flagStage;
    seedStage_t resultStage;
    firstBits_t flagsAnalysis;
    firstBits_t flagsResult;

    always_ff @(posedge clk) begin
        startStage.graph <= graph;
        startStage.extended <= extended;
        startStage.grabSeed <= grabSeed;
        // wait alongside the analysis register
        flagStage <= startStage;
        resultStage <= flagStage;
        flagsResult <= flagsAnalysis;
    end

    firstBitAnalysis analysis (
        .clk   (clk),
        .graph (startStage.graph),
        .flags (flagsAnalysis)
    );

    seedProducer producer (
        .graph        (resultStage.graph),
        .extended     (resultStage.extended),
        .grabSeed     (resultStage.grabSeed),
        .flags        (flagsResult),
        .newExtending (curExtending)
    );

    // a new seed counts only if there was a vertex to take
    assign incrementCount = resultStage.grabSeed & (|flagsResult.hasBit64);

endmodule

`default_nettype wire

/* rtl/hypercubeClosure.sv */
`default_nettype none
`timescale 1ns/1ps

module hypercubeClosure
    import graphPkg::*;
#(
    parameter bit UPWARD = 1'b1
) (
    input  graph_t vertices,
    output graph_t closure
);

    graph_t acc;

    // one level per index bit pushes vertices one step along that axis
    // after all seven levels every superset (or subset) is reached
    always_comb begin
        acc = vertices;
        for (int b = 0; b < 7; b++) begin
            for (int v = 0; v < graphBits; v++) begin
                if (UPWARD) begin
                    // vertex with bit b set takes from its neighbour without it
                    if (((v >> b) & 1) == 1) begin
                        acc[v] = acc[v] | acc[v ^ (1 << b)];
                    end
                end else begin
                    // vertex with bit b clear takes from its neighbour with it
                    if (((v >> b) & 1) == 0) begin
                        acc[v] = acc[v] | acc[v | (1 << b)];
                    end
                end
            end
        end
    end

    assign closure = acc;

endmodule

`default_nettype wire

/* rtl/hyperpipe.sv */
`default_nettype none
`timescale 1ns/1ps

module hyperpipe #(
    parameter int CYCLES = 1,
    parameter int WIDTH = 1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] in,
    output logic [WIDTH-1:0] out
);

    logic [WIDTH-1:0] stages [CYCLES];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < CYCLES; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= in;
            for (int i = 1; i < CYCLES; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign out = stages[CYCLES-1];

endmodule

`default_nettype wire

/* rtl/loopPkg.sv */
`default_nettype none

package loopPkg;

    // stage latencies of one lap through the loop
    localparam int seedLatency = 3;
    localparam int midLatency = 1;
    localparam int explorationLatency = 3;
    localparam int outLatency = 1;

    // slot state without the caller tag
    // the tag width is a module parameter, so it rides next to this struct
    typedef struct packed {
        // vertices not yet assigned to a finished component
        graphPkg::graph_t leftover;
        // component grown so far
        graphPkg::graph_t extended;
        // leftover ran empty and the slot is free
        logic runEnd;
        // growth settled so a new seed comes next lap
        logic grabSeed;
        logic valid;
        graphPkg::count_t count;
    } loopStateFixed_t;

    localparam int fixedStateBits = $bits(loopStateFixed_t);

endpackage

`default_nettype wire

/* rtl/graphPkg.sv */
`default_nettype none

package graphPkg;

    // one vertex per index of the 7-cube
    localparam int graphBits = 128;

    // bit v set means vertex v is in the set
    typedef logic [graphBits-1:0] graph_t;

    // at most 35 pairwise incomparable vertices, so 6 bits suffice
    typedef logic [5:0] count_t;

    // group-level first-vertex flags between the two seed stages
    typedef struct packed {
        // any vertex in each 64-vertex half
        logic [1:0] hasBit64;
        // one-hot mark of the 16-group holding the first vertex in each 64-group
        logic [7:0] hasFirstBit16;
        // one-hot mark of the 4-group holding the first vertex in each 16-group
        logic [31:0] hasFirstBit4;
    } firstBits_t;

endpackage

`default_nettype wire
